// File: hdl/fetch_consts.svh
/* fetch front end constants
   queue sizing, boot base, byte order and fixed instruction words */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// queue depth is 2**FETCH_QUE_ADDR_WIDTH entries
`define FETCH_QUE_ADDR_WIDTH 4
// free slots at or below this raise almost_full
`define FETCH_ALMOST_FULL_MARGIN 2

`define FETCH_BOOT_BASE 32'h0001_0000

// 1 swaps the bytes of every fetched word before issue
`define FETCH_LITTLE_ENDIAN 1

`define INSTR_ECALL 32'h0000_0073
`define INSTR_NOP 32'h0000_0013

`endif

// File: hdl/core_types_pkg.sv
/* core word types
   machine word, instruction word and fetch FSM states */
package core_types_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] data_t;
	typedef logic [xlen-1:0] instr_t;

	// DEBUG    idle, control is with the debugger
	// FETCH    reads are issued to instruction memory
	// STALL    queue is almost full, no new reads
	// ECALL_WAIT  fetched an ecall, waiting for it to retire
	typedef enum logic [1:0] {
		DEBUG,
		FETCH,
		STALL,
		ECALL_WAIT
	} fetch_state_t;

endpackage : core_types_pkg

// File: hdl/fetch_bus_pkg.sv
/* fetch stage link types
   packed structs passed between fetch stages and to decode */
package fetch_bus_pkg;

	typedef struct packed {
		core_types_pkg::instr_t instr;
		core_types_pkg::data_t  pc;
	} queue_entry_t;

	typedef struct packed {
		core_types_pkg::instr_t instr;
		core_types_pkg::data_t  pc;
		logic                   valid;
	} issue_t;

	typedef struct packed {
		logic                   request;
		core_types_pkg::data_t  target;
	} redirect_t;

endpackage : fetch_bus_pkg

// File: hdl/pc_gen.sv
/* program counter stage
   boot load, redirect capture and advance on completed fetches */
`include "fetch_consts.svh"

module pc_gen (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     go,
	input  logic [9:0]               boot_index,
	input  fetch_bus_pkg::redirect_t redirect,
	input  logic                     fetch_advance,
	input  logic                     response_pending,
	output core_types_pkg::data_t    pc
);
	import core_types_pkg::*;

	logic  booted;
	logic  hold_valid;
	data_t hold_target;
	data_t boot_pc;

	assign boot_pc = `FETCH_BOOT_BASE + (data_t'(boot_index) << 2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			booted     <= 1'b0;
			hold_valid <= 1'b0;
			pc         <= `FETCH_BOOT_BASE;
		end else begin
			if (go)
				booted <= 1'b1;

			// a target seen mid-read waits for that read to come back
			if (redirect.request && response_pending)
				hold_valid <= 1'b1;
			else if (redirect.request || fetch_advance)
				hold_valid <= 1'b0;

			if (go && !booted)
				pc <= boot_pc;
			else if (redirect.request && !response_pending)
				pc <= redirect.target;
			else if (fetch_advance)
				pc <= hold_valid ? hold_target : pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (redirect.request)
			hold_target <= redirect.target;
	end

endmodule : pc_gen

// File: hdl/fetch_ctrl.sv
/* fetch control FSM
   issues memory reads, enqueues responses and drops stale ones after a flush */
`include "fetch_consts.svh"

module fetch_ctrl (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        go,
	input  logic                        flush,
	input  core_types_pkg::data_t       pc,
	input  logic                        almost_full,
	input  core_types_pkg::instr_t      retired_instr,
	output core_types_pkg::data_t       mem_addr,
	output logic                        mem_rd,
	input  core_types_pkg::data_t       mem_rdata,
	input  logic                        mem_done,
	output logic                        fetch_advance,
	output logic                        response_pending,
	output logic                        enq,
	output fetch_bus_pkg::queue_entry_t enq_entry
);
	import core_types_pkg::*;

	fetch_state_t state, state_next;
	logic         discard;
	logic         read_done;
	logic         is_ecall;

	assign read_done        = mem_rd && mem_done;
	assign response_pending = mem_rd && !mem_done;
	assign fetch_advance    = read_done;
	assign is_ecall         = (mem_rdata == `INSTR_ECALL);

	// responses made stale by a flush never reach the queue
	assign enq       = read_done && !discard && !flush;
	assign enq_entry = '{instr: mem_rdata, pc: pc};
	// pc only moves on completion or redirect, so it holds the read address
	assign mem_addr  = pc;

	always_comb begin
		state_next = state;
		unique case (state)
			DEBUG:
				if (go)
					state_next = FETCH;
			FETCH:
				if (response_pending)
					state_next = FETCH;
				else if (enq && is_ecall)
					state_next = ECALL_WAIT;
				else if (almost_full)
					state_next = STALL;
			STALL:
				if (!almost_full)
					state_next = FETCH;
			ECALL_WAIT:
				// an older branch taken means the ecall will never retire
				if (flush)
					state_next = FETCH;
				else if (retired_instr == `INSTR_ECALL)
					state_next = DEBUG;
			default:
				state_next = DEBUG;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= DEBUG;
			mem_rd  <= 1'b0;
			discard <= 1'b0;
		end else begin
			state <= state_next;
			// read starts one cycle into FETCH and chains back to back
			mem_rd <= (state == FETCH) && (state_next == FETCH);
			if (flush && response_pending)
				discard <= 1'b1;
			else if (mem_done)
				discard <= 1'b0;
		end
	end

endmodule : fetch_ctrl

// File: hdl/instr_queue.sv
/* instruction queue
   circular buffer of instruction and pc pairs with flush and almost-full level */
`include "fetch_consts.svh"

module instr_queue (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        flush,
	input  logic                        enq,
	input  fetch_bus_pkg::queue_entry_t enq_entry,
	input  logic                        deq,
	output fetch_bus_pkg::queue_entry_t head,
	output logic                        empty,
	output logic                        almost_full
);
	import fetch_bus_pkg::*;

	localparam int aw    = `FETCH_QUE_ADDR_WIDTH;
	localparam int depth = 1 << aw;

	queue_entry_t   entries [depth];
	logic [aw-1:0]  wr_ptr;
	logic [aw-1:0]  rd_ptr;
	logic [aw:0]    count;

	assign head        = entries[rd_ptr];
	assign empty       = (count == '0);
	assign almost_full = ((depth - count) <= `FETCH_ALMOST_FULL_MARGIN);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (enq)
				wr_ptr <= wr_ptr + 1'b1;
			if (deq)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous enq and deq leave the count unchanged
			if (enq && !deq)
				count <= count + 1'b1;
			else if (deq && !enq)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (enq)
			entries[wr_ptr] <= enq_entry;
	end

endmodule : instr_queue

// File: hdl/issue_stage.sv
/* issue stage
   output register toward decode, applies byte order and holds under stall */
`include "fetch_consts.svh"

module issue_stage (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        flush,
	input  logic                        stall,
	input  fetch_bus_pkg::queue_entry_t head,
	input  logic                        empty,
	output logic                        deq,
	output fetch_bus_pkg::issue_t       issue
);
	import core_types_pkg::*;

	localparam bit little_endian = `FETCH_LITTLE_ENDIAN;

	logic   valid;
	logic   load;
	instr_t instr_q;
	data_t  pc_q;
	instr_t head_instr;

	assign head_instr = little_endian ?
		{head.instr[7:0], head.instr[15:8], head.instr[23:16], head.instr[31:24]} :
		head.instr;

	// register may take a new word when it is empty or decode accepts it
	assign load = !valid || !stall;
	assign deq  = load && !empty && !flush;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid <= 1'b0;
		else if (flush)
			valid <= 1'b0;
		else if (load)
			valid <= !empty;
	end

	always_ff @(posedge clk) begin
		if (deq) begin
			instr_q <= head_instr;
			pc_q    <= head.pc;
		end
	end

	assign issue.valid = valid;
	assign issue.instr = valid ? instr_q : `INSTR_NOP;
	assign issue.pc    = valid ? pc_q : '0;

endmodule : issue_stage

// File: hdl/fetch_top.sv
/* instruction fetch front end
   pc_gen, fetch_ctrl, instr_queue and issue_stage in a pipeline */
module fetch_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     go,
	input  logic [9:0]               boot_index,
	input  fetch_bus_pkg::redirect_t redirect,
	input  logic                     stall,
	input  core_types_pkg::instr_t   retired_instr,
	output core_types_pkg::data_t    mem_addr,
	output logic                     mem_rd,
	input  core_types_pkg::data_t    mem_rdata,
	input  logic                     mem_done,
	output fetch_bus_pkg::issue_t    issue
);
	import core_types_pkg::*;
	import fetch_bus_pkg::*;

	data_t        pc;
	logic         fetch_advance;
	logic         response_pending;
	logic         enq;
	queue_entry_t enq_entry;
	queue_entry_t head;
	logic         empty;
	logic         almost_full;
	logic         deq;

	pc_gen u_pc_gen (
		.clk              (clk),
		.rst_n            (rst_n),
		.go               (go),
		.boot_index       (boot_index),
		.redirect         (redirect),
		.fetch_advance    (fetch_advance),
		.response_pending (response_pending),
		.pc               (pc)
	);

	fetch_ctrl u_fetch_ctrl (
		.clk              (clk),
		.rst_n            (rst_n),
		.go               (go),
		.flush            (redirect.request),
		.pc               (pc),
		.almost_full      (almost_full),
		.retired_instr    (retired_instr),
		.mem_addr         (mem_addr),
		.mem_rd           (mem_rd),
		.mem_rdata        (mem_rdata),
		.mem_done         (mem_done),
		.fetch_advance    (fetch_advance),
		.response_pending (response_pending),
		.enq              (enq),
		.enq_entry        (enq_entry)
	);

	instr_queue u_instr_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush       (redirect.request),
		.enq         (enq),
		.enq_entry   (enq_entry),
		.deq         (deq),
		.head        (head),
		.empty       (empty),
		.almost_full (almost_full)
	);

	issue_stage u_issue_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (redirect.request),
		.stall (stall),
		.head  (head),
		.empty (empty),
		.deq   (deq),
		.issue (issue)
	);

endmodule : fetch_top

// File: tests/fetch_sva.sv
/* fetch front end assertions
   memory read hold, stall hold, flush clear and ecall quiet */
module fetch_sva (
	input logic                         clk,
	input logic                         rst_n,
	input logic                         mem_rd,
	input logic                         mem_done,
	input core_types_pkg::data_t        mem_addr,
	input logic                         stall,
	input fetch_bus_pkg::redirect_t     redirect,
	input fetch_bus_pkg::issue_t        issue,
	input core_types_pkg::fetch_state_t state
);
	timeunit 1ns;
	timeprecision 1ps;
	import core_types_pkg::*;

	// a read keeps its strobe and address until memory answers
	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rd && !mem_done |=> mem_rd && $stable(mem_addr))
		else $error("mem_rd or mem_addr changed before mem_done");

	issue_held: assert property (@(posedge clk) disable iff (!rst_n)
		issue.valid && stall && !redirect.request |=> $stable(issue))
		else $error("issue changed while decode stalled");

	flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
		redirect.request |=> !issue.valid)
		else $error("valid issue on the cycle after a flush");

	ecall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		state == ECALL_WAIT |-> !mem_rd)
		else $error("memory read issued while waiting for ecall to retire");

endmodule : fetch_sva

bind fetch_top fetch_sva u_sva (
	.clk      (clk),
	.rst_n    (rst_n),
	.mem_rd   (mem_rd),
	.mem_done (mem_done),
	.mem_addr (mem_addr),
	.stall    (stall),
	.redirect (redirect),
	.issue    (issue),
	.state    (u_fetch_ctrl.state)
);

// File: tests/fetch_checker.sv
/* fetch checker
   tracks the expected pc stream and compares every word decode accepts */
`include "fetch_consts.svh"

module fetch_checker (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     go,
	input  logic [9:0]               boot_index,
	input  fetch_bus_pkg::redirect_t redirect,
	input  logic                     stall,
	input  fetch_bus_pkg::issue_t    issue,
	input  core_types_pkg::data_t    ecall_addr,
	input  logic                     hold_idle,
	input  int                       test_num,
	input  logic                     test_end,
	input  logic                     all_done,
	output int                       errors,
	output int                       checks
);
	timeunit 1ns;
	timeprecision 1ps;
	import core_types_pkg::*;

	localparam bit little_endian = `FETCH_LITTLE_ENDIAN;

	logic  booted;
	data_t exp_pc;
	int    test_checks;
	int    test_errors;

	// memory contents, one ecall address and a mixed word everywhere else
	function automatic data_t stored_word(input data_t addr);
		data_t m;
		if (addr == ecall_addr)
			return `INSTR_ECALL;
		m = (addr ^ 32'h6c3a_e51d) * 32'h9e37_79b1;
		m = m ^ (m >> 15);
		return {m[31:7], 7'h33};
	endfunction

	function automatic instr_t expected_word(input data_t pc);
		data_t w;
		w = stored_word(pc);
		if (little_endian)
			return {w[7:0], w[15:8], w[23:16], w[31:24]};
		return w;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			booted      <= 1'b0;
			exp_pc      <= `FETCH_BOOT_BASE;
			errors      <= 0;
			checks      <= 0;
			test_checks <= 0;
			test_errors <= 0;
		end else begin
			if (go && !booted) begin
				booted <= 1'b1;
				exp_pc <= `FETCH_BOOT_BASE + {20'd0, boot_index, 2'b00};
			end else if (redirect.request) begin
				// the word in issue is younger than the branch and is dropped
				exp_pc <= redirect.target;
			end else if (issue.valid && !stall) begin
				checks      <= checks + 1;
				test_checks <= test_checks + 1;
				exp_pc      <= exp_pc + 32'd4;
				if (issue.pc !== exp_pc || issue.instr !== expected_word(exp_pc)) begin
					$display("Mismatch at %0t: expected pc %h word %h, got pc %h word %h",
						$time, exp_pc, expected_word(exp_pc), issue.pc, issue.instr);
					errors      <= errors + 1;
					test_errors <= test_errors + 1;
				end
			end
			if (hold_idle && issue.valid) begin
				$display("at %0t an instruction was issued after the ecall, pc %h",
					$time, issue.pc);
				errors      <= errors + 1;
				test_errors <= test_errors + 1;
			end
			if (test_end) begin
				$display("test %0d finished: %0d compared, %0d errors",
					test_num, test_checks, test_errors);
				test_checks <= 0;
				test_errors <= 0;
			end
			if (all_done)
				$display("all tests finished: %0d compared, %0d errors", checks, errors);
		end
	end

endmodule : fetch_checker

// File: tests/fetch_tb.sv
/* fetch front end testbench
   clock, reset, instruction memory model and the test sequence */
`include "fetch_consts.svh"

module fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import core_types_pkg::*;
	import fetch_bus_pkg::*;

	localparam int max_lat      = 4;
	localparam int fill_words   = 1 << `FETCH_QUE_ADDR_WIDTH;
	localparam int len_boot     = 16;
	localparam int len_stall    = 24;
	localparam int len_flush    = 14;
	localparam int len_ecall    = 15;
	localparam int len_pressure = 30;
	localparam int total_words  = len_boot + len_stall + len_flush + len_ecall
		+ len_pressure + 2 * fill_words;
	// every word may take max_lat + 1 cycles, doubled for random stall
	localparam int timeout_cycles = total_words * (max_lat + 1) * 2 + 600;

	localparam data_t flush_busy_target = 32'h0002_0000;
	localparam data_t flush_idle_target = 32'h0003_0400;
	localparam data_t ecall_target      = 32'h0004_0000;

	logic       clk;
	logic       rst_n;
	logic       go;
	logic [9:0] boot_index;
	redirect_t  redirect;
	logic       stall;
	instr_t     retired_instr;
	data_t      mem_addr;
	logic       mem_rd;
	data_t      mem_rdata;
	logic       mem_done;
	issue_t     issue;

	integer seed = 32'h1f5a;
	int     fixed_lat;
	int     stall_mode;
	logic   mem_busy;
	int     wait_left;
	data_t  ecall_addr;
	logic   hold_idle;
	int     test_num;
	logic   test_end;
	logic   all_done;
	int     chk_errors;
	int     chk_checks;

	fetch_top dut (.*);

	fetch_checker checker_inst (
		.errors (chk_errors),
		.checks (chk_checks),
		.*
	);

	function automatic data_t memory_word(input data_t addr);
		data_t m;
		if (addr == ecall_addr)
			return `INSTR_ECALL;
		m = (addr ^ 32'h6c3a_e51d) * 32'h9e37_79b1;
		m = m ^ (m >> 15);
		// opcode field 0x33 keeps mixed words clear of ecall
		return {m[31:7], 7'h33};
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// memory answers 1 to max_lat cycles after it first sees mem_rd
	// decode stall follows stall_mode, 0 low, 1 random, 2 held high
	initial begin : memory_and_stall
		logic [31:0] r;
		int          lat;
		mem_done  = 1'b0;
		mem_rdata = '0;
		mem_busy  = 1'b0;
		wait_left = 0;
		stall     = 1'b0;
		forever begin
			@(posedge clk);
			case (stall_mode)
				1: begin
					r = $random(seed);
					stall <= r[0];
				end
				2: stall <= 1'b1;
				default: stall <= 1'b0;
			endcase
			mem_done <= 1'b0;
			if (mem_rd && !mem_done) begin
				if (mem_busy && wait_left != 0) begin
					wait_left <= wait_left - 1;
				end else if (mem_busy) begin
					mem_done  <= 1'b1;
					mem_rdata <= memory_word(mem_addr);
					mem_busy  <= 1'b0;
				end else begin
					r   = $random(seed);
					lat = (fixed_lat != 0) ? fixed_lat : 1 + int'(r[1:0]);
					if (lat == 1) begin
						mem_done  <= 1'b1;
						mem_rdata <= memory_word(mem_addr);
					end else begin
						mem_busy  <= 1'b1;
						wait_left <= lat - 2;
					end
				end
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles in test %0d", cycles, test_num);
		$display("=== FAIL ===");
		$finish;
	end

	// counts words that decode accepts
	task automatic wait_issues(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(posedge clk);
			if (issue.valid && !stall && !redirect.request)
				seen++;
		end
	endtask

	// back-pressure shows as mem_rd low for several cycles
	task automatic wait_fetch_idle();
		int quiet;
		quiet = 0;
		while (quiet < 4) begin
			@(posedge clk);
			quiet = mem_rd ? 0 : quiet + 1;
		end
	endtask

	task automatic wait_read_start();
		logic started;
		started = 1'b0;
		while (!started) begin
			@(posedge clk);
			started = mem_rd && !mem_done && !mem_busy;
		end
	endtask

	task automatic wait_ecall_issue();
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(posedge clk);
			seen = issue.valid && !stall && (issue.pc == ecall_addr);
		end
	endtask

	task automatic pulse_redirect(input data_t target);
		redirect <= '{request: 1'b1, target: target};
		@(posedge clk);
		redirect <= '0;
	endtask

	task automatic pulse_go();
		go <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
	endtask

	task automatic end_test(input int n);
		test_num <= n;
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	initial begin : main_sequence
		logic [31:0] r;
		rst_n         = 1'b0;
		go            = 1'b0;
		boot_index    = '0;
		redirect      = '0;
		retired_instr = `INSTR_NOP;
		fixed_lat     = 0;
		stall_mode    = 0;
		ecall_addr    = '0;
		hold_idle     = 1'b0;
		test_num      = 0;
		test_end      = 1'b0;
		all_done      = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// boot and straight-line fetch
		test_num <= 1;
		r = $random(seed);
		boot_index <= r[9:0];
		@(posedge clk);
		pulse_go();
		wait_issues(len_boot);
		end_test(1);

		test_num <= 2;
		stall_mode <= 1;
		wait_issues(len_stall);
		stall_mode <= 0;
		end_test(2);

		// flush with a read in flight, then with fetch held back
		test_num <= 3;
		fixed_lat <= max_lat;
		wait_read_start();
		pulse_redirect(flush_busy_target);
		wait_issues(len_flush / 2);
		stall_mode <= 2;
		wait_fetch_idle();
		stall_mode <= 0;
		fixed_lat <= 0;
		pulse_redirect(flush_idle_target);
		wait_issues(len_flush / 2);
		end_test(3);

		test_num <= 4;
		ecall_addr <= ecall_target + 32'd24;
		pulse_redirect(ecall_target);
		wait_ecall_issue();
		hold_idle <= 1'b1;
		repeat (8) @(posedge clk);
		hold_idle <= 1'b0;
		retired_instr <= `INSTR_ECALL;
		@(posedge clk);
		retired_instr <= `INSTR_NOP;
		@(posedge clk);
		pulse_go();
		wait_issues(8);
		end_test(4);

		// fill the queue to almost full behind a long stall
		test_num <= 5;
		fixed_lat <= 1;
		stall_mode <= 2;
		wait_fetch_idle();
		stall_mode <= 0;
		wait_issues(len_pressure);
		fixed_lat <= 0;
		end_test(5);

		all_done <= 1'b1;
		@(posedge clk);
		all_done <= 1'b0;
		repeat (2) @(posedge clk);
		if (chk_errors == 0 && chk_checks > 0) begin
			$display("=== PASS ===");
		end else begin
			if (chk_checks == 0)
				$display("no issued instruction was compared");
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule : fetch_tb

// File: compile.f
+incdir+hdl
hdl/core_types_pkg.sv
hdl/fetch_bus_pkg.sv
hdl/pc_gen.sv
hdl/fetch_ctrl.sv
hdl/instr_queue.sv
hdl/issue_stage.sv
hdl/fetch_top.sv
tests/fetch_sva.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// File: Makefile
# Verilator flow for the instruction fetch front end

VERILATOR   ?= verilator
TOP         ?= fetch_tb
FILELIST    ?= compile.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --timing --assert
PASS_STRING ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_STRING)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
